//--- common/he_cfg_pkg.sv
package he_cfg_pkg;

   ////////////////////////////////////////
   // datapath and memory widths
   ////////////////////////////////////////

   localparam int WORD_W       = 27;
   localparam int ADDR_W       = 40;

   // banks 0-3 hold operand A, banks 4-7 hold operand B
   localparam int NUM_BANKS    = 8;
   localparam int BANKS_PER_OP = 4;

   // target of the completion interrupt write
   localparam logic [ADDR_W-1:0] INTR_ADDR = 40'h30_0000;

   typedef logic [WORD_W-1:0] he_word_t;

   ////////////////////////////////////////
   // host register map
   ////////////////////////////////////////

   typedef enum logic [7:0] {
      CSR_Q      = 8'h00,
      CSR_A_PTR  = 8'h01,
      CSR_B_PTR  = 8'h02,
      CSR_WB_PTR = 8'h03,
      CSR_START  = 8'h04,
      CSR_STATUS = 8'h05
   } csr_addr_e;

   // job sequencing, one state per phase of a run
   typedef enum logic [2:0] {
      SEQ_IDLE,
      SEQ_LOAD_A,
      SEQ_LOAD_B,
      SEQ_ADD,
      SEQ_STORE,
      SEQ_INTR
   } seq_state_e;

   typedef enum logic [1:0] {
      DMA_LOAD_A,
      DMA_LOAD_B,
      DMA_STORE,
      DMA_INTR
   } dma_kind_e;

endpackage

//--- common/he_bus_pkg.sv
package he_bus_pkg;

   ////////////////////////////////////////
   // host command port
   ////////////////////////////////////////

   typedef struct packed {
      he_cfg_pkg::csr_addr_e idx;
      logic                  wr;
      logic [31:0]           data;
   } csr_cmd_t;

   // every command gets one of these, reads carry the register value
   typedef struct packed {
      logic [31:0] data;
   } csr_rsp_t;

   ////////////////////////////////////////
   // external memory port
   ////////////////////////////////////////

   typedef struct packed {
      logic [he_cfg_pkg::ADDR_W-1:0] addr;
      logic                          wr;
      he_cfg_pkg::he_word_t          data;
   } mem_req_t;

   typedef struct packed {
      he_cfg_pkg::he_word_t data;
   } mem_rsp_t;

   // work item from the sequencer to the transfer engine
   typedef struct packed {
      he_cfg_pkg::dma_kind_e         kind;
      logic [he_cfg_pkg::ADDR_W-1:0] base;
   } dma_job_t;

endpackage

//--- src/he_csr_file.sv
`timescale 1ns/1ps

module he_csr_file (
   input  logic                              clk_i,
   input  logic                              reset_i,
   input  logic                              csr_cmd_v_i,
   input  he_bus_pkg::csr_cmd_t              csr_cmd_i,
   output logic                              csr_rsp_v_o,
   output he_bus_pkg::csr_rsp_t              csr_rsp_o,
   input  logic                              busy_i,
   input  logic                              done_i,
   output logic                              start_o,
   output he_cfg_pkg::he_word_t              q_o,
   output logic [he_cfg_pkg::ADDR_W-1:0]     a_ptr_o,
   output logic [he_cfg_pkg::ADDR_W-1:0]     b_ptr_o,
   output logic [he_cfg_pkg::ADDR_W-1:0]     wb_ptr_o
);
   import he_cfg_pkg::*;

   he_word_t    q_r;
   logic [31:0] a_ptr_r;
   logic [31:0] b_ptr_r;
   logic [31:0] wb_ptr_r;
   logic [31:0] rd_data;
   logic        wr_en;

   assign wr_en = csr_cmd_v_i & csr_cmd_i.wr;

   // readback mux, START and unknown indices read as zero
   always_comb begin
      case (csr_cmd_i.idx)
         CSR_Q:      rd_data = 32'(q_r);
         CSR_A_PTR:  rd_data = a_ptr_r;
         CSR_B_PTR:  rd_data = b_ptr_r;
         CSR_WB_PTR: rd_data = wb_ptr_r;
         CSR_STATUS: rd_data = {30'b0, done_i, busy_i};
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         q_r         <= '0;
         a_ptr_r     <= '0;
         b_ptr_r     <= '0;
         wb_ptr_r    <= '0;
         csr_rsp_v_o <= 1'b0;
         start_o     <= 1'b0;
      end else begin
         csr_rsp_v_o <= csr_cmd_v_i;
         // start is a single pulse, the sequencer drops it while busy
         start_o     <= wr_en & (csr_cmd_i.idx == CSR_START) & csr_cmd_i.data[0];
         if (wr_en) begin
            case (csr_cmd_i.idx)
               CSR_Q:      q_r      <= csr_cmd_i.data[WORD_W-1:0];
               CSR_A_PTR:  a_ptr_r  <= csr_cmd_i.data;
               CSR_B_PTR:  b_ptr_r  <= csr_cmd_i.data;
               CSR_WB_PTR: wb_ptr_r <= csr_cmd_i.data;
               default:    ;
            endcase
         end
      end
   end

   // write acknowledges carry zero
   always_ff @(posedge clk_i) begin
      if (csr_cmd_v_i) begin
         csr_rsp_o.data <= csr_cmd_i.wr ? '0 : rd_data;
      end
   end

   assign q_o      = q_r;
   assign a_ptr_o  = ADDR_W'(a_ptr_r);
   assign b_ptr_o  = ADDR_W'(b_ptr_r);
   assign wb_ptr_o = ADDR_W'(wb_ptr_r);

endmodule

//--- he_core/he_sequencer.sv
`timescale 1ns/1ps

module he_sequencer (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          start_i,
   input  logic [he_cfg_pkg::ADDR_W-1:0] a_ptr_i,
   input  logic [he_cfg_pkg::ADDR_W-1:0] b_ptr_i,
   input  logic [he_cfg_pkg::ADDR_W-1:0] wb_ptr_i,
   output logic                          job_v_o,
   output he_bus_pkg::dma_job_t          job_o,
   input  logic                          job_done_i,
   output logic                          add_start_o,
   input  logic                          add_done_i,
   output logic                          busy_o,
   output logic                          done_o
);
   import he_cfg_pkg::*;
   import he_bus_pkg::*;

   seq_state_e state_r;
   seq_state_e state_n;
   dma_job_t   job_n;
   logic       job_v_n;
   logic       add_start_n;

   ////////////////////////////////////////
   // next state and job selection
   ////////////////////////////////////////

   // each state kicks off its job on entry and waits for the done strobe
   always_comb begin
      state_n     = state_r;
      job_v_n     = 1'b0;
      add_start_n = 1'b0;
      job_n       = job_o;
      case (state_r)
         SEQ_IDLE: begin
            if (start_i) begin
               state_n = SEQ_LOAD_A;
               job_v_n = 1'b1;
               job_n   = '{kind: DMA_LOAD_A, base: a_ptr_i};
            end
         end
         SEQ_LOAD_A: begin
            if (job_done_i) begin
               state_n = SEQ_LOAD_B;
               job_v_n = 1'b1;
               job_n   = '{kind: DMA_LOAD_B, base: b_ptr_i};
            end
         end
         SEQ_LOAD_B: begin
            if (job_done_i) begin
               state_n     = SEQ_ADD;
               add_start_n = 1'b1;
            end
         end
         SEQ_ADD: begin
            if (add_done_i) begin
               state_n = SEQ_STORE;
               job_v_n = 1'b1;
               job_n   = '{kind: DMA_STORE, base: wb_ptr_i};
            end
         end
         SEQ_STORE: begin
            if (job_done_i) begin
               state_n = SEQ_INTR;
               job_v_n = 1'b1;
               job_n   = '{kind: DMA_INTR, base: INTR_ADDR};
            end
         end
         SEQ_INTR: begin
            if (job_done_i) begin
               state_n = SEQ_IDLE;
            end
         end
         default: state_n = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_r     <= SEQ_IDLE;
         job_v_o     <= 1'b0;
         add_start_o <= 1'b0;
         done_o      <= 1'b0;
      end else begin
         state_r     <= state_n;
         job_v_o     <= job_v_n;
         add_start_o <= add_start_n;
         // done holds from the interrupt until the next accepted start
         if (state_r == SEQ_IDLE && start_i) begin
            done_o <= 1'b0;
         end else if (state_r == SEQ_INTR && job_done_i) begin
            done_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (job_v_n) begin
         job_o <= job_n;
      end
   end

   assign busy_o = (state_r != SEQ_IDLE);

endmodule

//--- he_core/he_dma_engine.sv
`timescale 1ns/1ps

module he_dma_engine #(
   parameter int log_n_p = 5
) (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 job_v_i,
   input  he_bus_pkg::dma_job_t job_i,
   output logic                 job_done_o,
   output logic                 mem_req_v_o,
   output he_bus_pkg::mem_req_t mem_req_o,
   input  logic                 mem_rsp_v_i,
   input  he_bus_pkg::mem_rsp_t mem_rsp_i,
   output logic                 ld_v_o,
   output logic                 ld_op_b_o,
   output logic [log_n_p-1:0]   ld_idx_o,
   output he_cfg_pkg::he_word_t ld_data_o,
   output logic                 st_rd_v_o,
   output logic [log_n_p-1:0]   st_idx_o,
   input  he_cfg_pkg::he_word_t st_data_i
);
   import he_cfg_pkg::*;

   dma_kind_e          kind_r;
   dma_kind_e          kind_n;
   logic [ADDR_W-1:0]  base_r;
   logic [log_n_p-1:0] idx_r;
   logic               out_r;
   logic               rsp_ok;
   logic               last;
   logic               issue;

   // only a response to our own outstanding request counts
   assign rsp_ok = mem_rsp_v_i & out_r;
   assign last   = (kind_r == DMA_INTR) | (idx_r == '1);
   assign issue  = job_v_i | (rsp_ok & ~last);
   assign kind_n = job_v_i ? job_i.kind : kind_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         out_r       <= 1'b0;
         mem_req_v_o <= 1'b0;
         st_rd_v_o   <= 1'b0;
         job_done_o  <= 1'b0;
      end else begin
         // stores take an extra cycle for the buffer read
         mem_req_v_o <= (issue & (kind_n != DMA_STORE)) | st_rd_v_o;
         st_rd_v_o   <= issue & (kind_n == DMA_STORE);
         job_done_o  <= rsp_ok & last;
         if (mem_req_v_o) begin
            out_r <= 1'b1;
         end else if (mem_rsp_v_i) begin
            out_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (job_v_i) begin
         kind_r <= job_i.kind;
         base_r <= job_i.base;
         idx_r  <= '0;
      end else if (rsp_ok & ~last) begin
         idx_r <= idx_r + 1'b1;
      end
   end

   ////////////////////////////////////////
   // request formation and load routing
   ////////////////////////////////////////

   assign mem_req_o.addr = base_r + (ADDR_W'(idx_r) << 2);
   assign mem_req_o.wr   = (kind_r == DMA_STORE) | (kind_r == DMA_INTR);
   assign mem_req_o.data = (kind_r == DMA_INTR)  ? '1 :
                           (kind_r == DMA_STORE) ? st_data_i : '0;

   assign ld_v_o    = rsp_ok & ((kind_r == DMA_LOAD_A) | (kind_r == DMA_LOAD_B));
   assign ld_op_b_o = (kind_r == DMA_LOAD_B);
   assign ld_idx_o  = idx_r;
   assign ld_data_o = mem_rsp_i.data;
   assign st_idx_o  = idx_r;

endmodule

//--- he_core/he_poly_buffer.sv
`timescale 1ns/1ps

module he_poly_buffer #(
   parameter int log_n_p = 5
) (
   input  logic                                                   clk_i,
   input  logic                                                   ld_v_i,
   input  logic                                                   ld_op_b_i,
   input  logic [log_n_p-1:0]                                     ld_idx_i,
   input  he_cfg_pkg::he_word_t                                   ld_data_i,
   input  logic                                                   st_rd_v_i,
   input  logic [log_n_p-1:0]                                     st_idx_i,
   output he_cfg_pkg::he_word_t                                   st_data_o,
   input  logic                                                   alu_rd_v_i,
   input  logic [he_cfg_pkg::BANKS_PER_OP-1:0]                    alu_rd_bank_i,
   input  logic [log_n_p-3:0]                                     alu_rd_row_i,
   output he_cfg_pkg::he_word_t [he_cfg_pkg::BANKS_PER_OP-1:0]    alu_a_o,
   output he_cfg_pkg::he_word_t [he_cfg_pkg::BANKS_PER_OP-1:0]    alu_b_o,
   input  logic                                                   alu_wr_v_i,
   input  logic [he_cfg_pkg::BANKS_PER_OP-1:0]                    alu_wr_bank_i,
   input  logic [log_n_p-3:0]                                     alu_wr_row_i,
   input  he_cfg_pkg::he_word_t [he_cfg_pkg::BANKS_PER_OP-1:0]    alu_wr_data_i
);
   import he_cfg_pkg::*;

   localparam int ROW_W = log_n_p - 2;
   localparam int DEPTH = 2 ** ROW_W;

   logic [log_n_p-1:0] ld_rev;
   logic [log_n_p-1:0] st_rev;
   logic [1:0]         ld_lane;
   logic [1:0]         st_lane;
   logic [1:0]         st_lane_r;
   logic [ROW_W-1:0]   ld_row;
   logic [ROW_W-1:0]   st_row;
   he_word_t           rd_data [NUM_BANKS];

   // bit-reversed placement, low bits pick the bank and the rest the row
   assign ld_rev  = {<<{ld_idx_i}};
   assign st_rev  = {<<{st_idx_i}};
   assign ld_lane = ld_rev[1:0];
   assign st_lane = st_rev[1:0];
   assign ld_row  = ld_rev[log_n_p-1:2];
   assign st_row  = st_rev[log_n_p-1:2];

   ////////////////////////////////////////
   // one-read-one-write banks
   ////////////////////////////////////////

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      localparam bit IS_B = (b >= BANKS_PER_OP);
      localparam int LANE = b % BANKS_PER_OP;

      he_word_t         mem [DEPTH];
      he_word_t         rd_q;
      he_word_t         wr_data;
      logic [ROW_W-1:0] wr_row;
      logic [ROW_W-1:0] rd_row;
      logic             ld_hit;
      logic             alu_wr_hit;
      logic             st_hit;
      logic             alu_rd_hit;

      assign ld_hit     = ld_v_i & (ld_op_b_i == IS_B) & (ld_lane == 2'(LANE));
      // sums go back over A, stores read A
      assign alu_wr_hit = !IS_B & alu_wr_v_i & alu_wr_bank_i[LANE];
      assign st_hit     = !IS_B & st_rd_v_i & (st_lane == 2'(LANE));
      assign alu_rd_hit = alu_rd_v_i & alu_rd_bank_i[LANE];

      assign wr_row  = ld_hit ? ld_row : alu_wr_row_i;
      assign wr_data = ld_hit ? ld_data_i : alu_wr_data_i[LANE];
      assign rd_row  = st_hit ? st_row : alu_rd_row_i;

      always_ff @(posedge clk_i) begin
         if (ld_hit | alu_wr_hit) begin
            mem[wr_row] <= wr_data;
         end
         if (st_hit | alu_rd_hit) begin
            rd_q <= mem[rd_row];
         end
      end

      assign rd_data[b] = rd_q;
   end

   // remember which A bank the store read went to
   always_ff @(posedge clk_i) begin
      if (st_rd_v_i) begin
         st_lane_r <= st_lane;
      end
   end

   assign st_data_o = rd_data[st_lane_r];

   for (genvar p = 0; p < BANKS_PER_OP; p++) begin : g_pair
      assign alu_a_o[p] = rd_data[p];
      assign alu_b_o[p] = rd_data[p + BANKS_PER_OP];
   end

endmodule

//--- he_core/he_pointwise_adder.sv
`timescale 1ns/1ps

module he_pointwise_adder #(
   parameter int log_n_p = 5
) (
   input  logic                                                clk_i,
   input  logic                                                reset_i,
   input  logic                                                start_i,
   output logic                                                done_o,
   input  he_cfg_pkg::he_word_t                                q_i,
   output logic                                                alu_rd_v_o,
   output logic [he_cfg_pkg::BANKS_PER_OP-1:0]                 alu_rd_bank_o,
   output logic [log_n_p-3:0]                                  alu_rd_row_o,
   input  he_cfg_pkg::he_word_t [he_cfg_pkg::BANKS_PER_OP-1:0] alu_a_i,
   input  he_cfg_pkg::he_word_t [he_cfg_pkg::BANKS_PER_OP-1:0] alu_b_i,
   output logic                                                alu_wr_v_o,
   output logic [he_cfg_pkg::BANKS_PER_OP-1:0]                 alu_wr_bank_o,
   output logic [log_n_p-3:0]                                  alu_wr_row_o,
   output he_cfg_pkg::he_word_t [he_cfg_pkg::BANKS_PER_OP-1:0] alu_wr_data_o
);
   import he_cfg_pkg::*;

   logic [WORD_W:0] sum  [BANKS_PER_OP];
   logic [WORD_W:0] diff [BANKS_PER_OP];

   // all four bank pairs of a row are handled together
   assign alu_rd_bank_o = {BANKS_PER_OP{alu_rd_v_o}};

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         alu_rd_v_o <= 1'b0;
         alu_wr_v_o <= 1'b0;
         done_o     <= 1'b0;
      end else begin
         if (start_i) begin
            alu_rd_v_o <= 1'b1;
         end else if (alu_rd_v_o && alu_rd_row_o == '1) begin
            alu_rd_v_o <= 1'b0;
         end
         alu_wr_v_o <= alu_rd_v_o;
         done_o     <= alu_wr_v_o & (alu_wr_row_o == '1);
      end
   end

   // row sweep, the write stage trails the read by one cycle
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         alu_rd_row_o <= '0;
      end else if (alu_rd_v_o) begin
         alu_rd_row_o <= alu_rd_row_o + 1'b1;
      end
      alu_wr_row_o  <= alu_rd_row_o;
      alu_wr_bank_o <= alu_rd_bank_o;
   end

   // both operands are below q so one subtraction is enough
   always_comb begin
      for (int p = 0; p < BANKS_PER_OP; p++) begin
         sum[p]  = {1'b0, alu_a_i[p]} + {1'b0, alu_b_i[p]};
         diff[p] = sum[p] - {1'b0, q_i};
         alu_wr_data_o[p] = (sum[p] >= {1'b0, q_i}) ? diff[p][WORD_W-1:0]
                                                    : sum[p][WORD_W-1:0];
      end
   end

endmodule

//--- src/he_accel_top.sv
`timescale 1ns/1ps

module he_accel_top #(
   parameter int log_n_p = 5
) (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 csr_cmd_v_i,
   input  he_bus_pkg::csr_cmd_t csr_cmd_i,
   output logic                 csr_rsp_v_o,
   output he_bus_pkg::csr_rsp_t csr_rsp_o,
   output logic                 mem_req_v_o,
   output he_bus_pkg::mem_req_t mem_req_o,
   input  logic                 mem_rsp_v_i,
   input  he_bus_pkg::mem_rsp_t mem_rsp_i
);
   import he_cfg_pkg::*;
   import he_bus_pkg::*;

   logic                           start, busy, done;
   he_word_t                       q;
   logic [ADDR_W-1:0]              a_ptr, b_ptr, wb_ptr;
   logic                           job_v, job_done;
   dma_job_t                       job;
   logic                           add_start, add_done;
   logic                           ld_v, ld_op_b, st_rd_v;
   logic [log_n_p-1:0]             ld_idx, st_idx;
   he_word_t                       ld_data, st_data;
   logic                           rd_v, wr_v;
   logic [BANKS_PER_OP-1:0]        rd_bank, wr_bank;
   logic [log_n_p-3:0]             rd_row, wr_row;
   he_word_t [BANKS_PER_OP-1:0]    alu_a, alu_b, wr_data;

   ////////////////////////////////////////
   // input side
   ////////////////////////////////////////

   he_csr_file csr_inst (
      .clk_i, .reset_i, .csr_cmd_v_i, .csr_cmd_i, .csr_rsp_v_o, .csr_rsp_o,
      .busy_i(busy), .done_i(done), .start_o(start), .q_o(q),
      .a_ptr_o(a_ptr), .b_ptr_o(b_ptr), .wb_ptr_o(wb_ptr)
   );

   // processing part
   he_sequencer seq_inst (
      .clk_i, .reset_i, .start_i(start),
      .a_ptr_i(a_ptr), .b_ptr_i(b_ptr), .wb_ptr_i(wb_ptr),
      .job_v_o(job_v), .job_o(job), .job_done_i(job_done),
      .add_start_o(add_start), .add_done_i(add_done),
      .busy_o(busy), .done_o(done)
   );

   he_pointwise_adder #(.log_n_p(log_n_p)) adder_inst (
      .clk_i, .reset_i, .start_i(add_start), .done_o(add_done), .q_i(q),
      .alu_rd_v_o(rd_v), .alu_rd_bank_o(rd_bank), .alu_rd_row_o(rd_row),
      .alu_a_i(alu_a), .alu_b_i(alu_b),
      .alu_wr_v_o(wr_v), .alu_wr_bank_o(wr_bank), .alu_wr_row_o(wr_row),
      .alu_wr_data_o(wr_data)
   );

   he_poly_buffer #(.log_n_p(log_n_p)) buf_inst (
      .clk_i, .ld_v_i(ld_v), .ld_op_b_i(ld_op_b), .ld_idx_i(ld_idx),
      .ld_data_i(ld_data), .st_rd_v_i(st_rd_v), .st_idx_i(st_idx),
      .st_data_o(st_data),
      .alu_rd_v_i(rd_v), .alu_rd_bank_i(rd_bank), .alu_rd_row_i(rd_row),
      .alu_a_o(alu_a), .alu_b_o(alu_b),
      .alu_wr_v_i(wr_v), .alu_wr_bank_i(wr_bank), .alu_wr_row_i(wr_row),
      .alu_wr_data_i(wr_data)
   );

   // output side
   he_dma_engine #(.log_n_p(log_n_p)) dma_inst (
      .clk_i, .reset_i, .job_v_i(job_v), .job_i(job), .job_done_o(job_done),
      .mem_req_v_o, .mem_req_o, .mem_rsp_v_i, .mem_rsp_i,
      .ld_v_o(ld_v), .ld_op_b_o(ld_op_b), .ld_idx_o(ld_idx), .ld_data_o(ld_data),
      .st_rd_v_o(st_rd_v), .st_idx_o(st_idx), .st_data_i(st_data)
   );

endmodule

//--- tb/he_mem_model.sv
`timescale 1ns/1ps

module he_mem_model (
   input  logic                 clk_i,
   input  logic                 req_v_i,
   input  he_bus_pkg::mem_req_t req_i,
   output logic                 rsp_v_o,
   output he_bus_pkg::mem_rsp_t rsp_o
);
   import he_cfg_pkg::*;
   import he_bus_pkg::*;

   // sparse word store, unwritten addresses read as zero
   he_word_t    words [logic [ADDR_W-1:0]];
   logic [31:0] rng = 32'd89345;
   logic        pend = 1'b0;
   int          wait_cnt = 0;
   he_word_t    rd_word = '0;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial begin
      rsp_v_o = 1'b0;
      rsp_o   = '0;
   end

   // requests are taken at the falling edge where the DUT outputs are settled
   always @(negedge clk_i) begin
      if (req_v_i === 1'b1) begin
         if (req_i.wr) begin
            words[req_i.addr] = req_i.data;
            rd_word = '0;
            $display("mem write addr=%h data=%h", req_i.addr, req_i.data);
         end else begin
            rd_word = words.exists(req_i.addr) ? words[req_i.addr] : '0;
         end
         // latency of 1 to 4 cycles
         rng      = xorshift32(rng);
         wait_cnt = 1 + int'(rng % 32'd4);
         pend     = 1'b1;
      end
   end

   always @(posedge clk_i) begin
      #1;
      rsp_v_o = 1'b0;
      if (pend) begin
         wait_cnt = wait_cnt - 1;
         if (wait_cnt == 0) begin
            rsp_v_o    = 1'b1;
            rsp_o.data = rd_word;
            pend       = 1'b0;
         end
      end
   end

endmodule

//--- tb/he_accel_tb.sv
`timescale 1ns/1ps

module he_accel_tb;
   import he_cfg_pkg::*;
   import he_bus_pkg::*;

   localparam int LOG_N     = 5;
   localparam int N         = 2 ** LOG_N;
   localparam int ROWS      = 3;
   localparam int MAX_CYCLE = ROWS * (6 * N * 5 + 100);

   // one accelerator run, pointers are byte addresses
   typedef struct packed {
      he_word_t    q;
      logic [31:0] a_ptr;
      logic [31:0] b_ptr;
      logic [31:0] wb_ptr;
   } run_cfg_t;

   logic        clk = 1'b0;
   logic        reset;
   logic        csr_cmd_v;
   csr_cmd_t    csr_cmd;
   logic        csr_rsp_v;
   csr_rsp_t    csr_rsp;
   logic        mem_req_v;
   mem_req_t    mem_req;
   logic        mem_rsp_v;
   mem_rsp_t    mem_rsp;

   run_cfg_t    runs [ROWS];
   mem_req_t    exp_reqs [$];
   mem_req_t    mon_exp;
   logic [31:0] rng = 32'd89345;
   int          cycles = 0;
   int          errors = 0;
   int          test_base = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          intr_seen = 0;
   logic        outstanding = 1'b0;

   always #5 clk = ~clk;

   he_accel_top #(.log_n_p(LOG_N)) he_accel_top_inst (
      .clk_i(clk), .reset_i(reset),
      .csr_cmd_v_i(csr_cmd_v), .csr_cmd_i(csr_cmd),
      .csr_rsp_v_o(csr_rsp_v), .csr_rsp_o(csr_rsp),
      .mem_req_v_o(mem_req_v), .mem_req_o(mem_req),
      .mem_rsp_v_i(mem_rsp_v), .mem_rsp_i(mem_rsp)
   );

   he_mem_model mem_inst (
      .clk_i(clk), .req_v_i(mem_req_v), .req_i(mem_req),
      .rsp_v_o(mem_rsp_v), .rsp_o(mem_rsp)
   );

   // run limit scales with the number of table rows
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLE) begin
         $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic mem_req_t make_req(input logic [ADDR_W-1:0] addr, input logic wr,
                                         input he_word_t data);
      mem_req_t r;
      r.addr = addr;
      r.wr   = wr;
      r.data = data;
      return r;
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic check_word(input string name, input he_word_t got, input he_word_t exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
         errors++;
      end
   endtask

   // address and direction, write data goes through check_word
   task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
      if (got.addr !== exp.addr || got.wr !== exp.wr) begin
         $display("FAIL t=%0t %s got=%h wr=%b exp=%h wr=%b", $time, name,
                  got.addr, got.wr, exp.addr, exp.wr);
         errors++;
      end
   endtask

   task automatic check_rsp(input string name, input csr_rsp_t got, input csr_rsp_t exp);
      if (got.data !== exp.data) begin
         $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got.data, exp.data);
         errors++;
      end
   endtask

   task automatic check_quiet(input string when);
      if (csr_rsp_v !== 1'b0 || mem_req_v !== 1'b0) begin
         $display("t=%0t unexpected strobe %s", $time, when);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (errors == test_base) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - test_base);
      end
   endtask

   ////////////////////////////////////////
   // memory bus monitor
   ////////////////////////////////////////

   always @(negedge clk) begin
      if (mem_rsp_v === 1'b1) begin
         outstanding = 1'b0;
      end
      if (mem_req_v === 1'b1) begin
         if (outstanding) begin
            $display("t=%0t memory request issued while another one is outstanding", $time);
            errors++;
         end
         outstanding = 1'b1;
         if (exp_reqs.size() == 0) begin
            $display("t=%0t unexpected memory request to %h", $time, mem_req.addr);
            errors++;
         end else begin
            mon_exp = exp_reqs.pop_front();
            check_req("mem_req_o", mem_req, mon_exp);
            if (mon_exp.wr) begin
               check_word("mem_req_o.data", mem_req.data, mon_exp.data);
            end
            if (mon_exp.wr && mon_exp.addr == INTR_ADDR) begin
               intr_seen++;
            end
         end
      end
   end

   // one command, response expected exactly one cycle later
   task automatic csr_access(input csr_addr_e idx, input logic wr, input logic [31:0] data,
                             output csr_rsp_t rsp);
      @(posedge clk);
      #1;
      csr_cmd_v    = 1'b1;
      csr_cmd.idx  = idx;
      csr_cmd.wr   = wr;
      csr_cmd.data = data;
      @(posedge clk);
      #1;
      csr_cmd_v = 1'b0;
      @(negedge clk);
      if (csr_rsp_v !== 1'b1) begin
         $display("t=%0t no register response one cycle after the command", $time);
         errors++;
      end
      rsp = csr_rsp;
      @(negedge clk);
      if (csr_rsp_v !== 1'b0) begin
         $display("t=%0t register response strobe lasted more than one cycle", $time);
         errors++;
      end
   endtask

   task automatic write_reg(input csr_addr_e idx, input logic [31:0] data);
      csr_rsp_t rsp;
      csr_access(idx, 1'b1, data, rsp);
   endtask

   task automatic read_check(input csr_addr_e idx, input logic [31:0] exp, input string name);
      csr_rsp_t rsp;
      csr_rsp_t exp_rsp;
      exp_rsp.data = exp;
      csr_access(idx, 1'b0, 32'h0, rsp);
      check_rsp(name, rsp, exp_rsp);
   endtask

   // poll STATUS until busy drops
   task automatic wait_idle();
      csr_rsp_t rsp;
      rsp.data = 32'h1;
      while (rsp.data[0] === 1'b1) begin
         csr_access(CSR_STATUS, 1'b0, 32'h0, rsp);
      end
   endtask

   task automatic run_row(input int k);
      run_cfg_t    cfg;
      he_word_t    a_ops [N];
      he_word_t    b_ops [N];
      logic [63:0] sum;
      cfg = runs[k];

      test_base = errors;
      write_reg(CSR_Q, 32'(cfg.q));
      write_reg(CSR_A_PTR, cfg.a_ptr);
      write_reg(CSR_B_PTR, cfg.b_ptr);
      write_reg(CSR_WB_PTR, cfg.wb_ptr);
      read_check(CSR_Q, 32'(cfg.q), "csr_rsp_o.data Q");
      read_check(CSR_A_PTR, cfg.a_ptr, "csr_rsp_o.data A_PTR");
      read_check(CSR_B_PTR, cfg.b_ptr, "csr_rsp_o.data B_PTR");
      read_check(CSR_WB_PTR, cfg.wb_ptr, "csr_rsp_o.data WB_PTR");
      read_check(csr_addr_e'(8'h3c), 32'h0, "csr_rsp_o.data unknown index");
      report_test($sformatf("row %0d registers", k));

      test_base = errors;
      read_check(CSR_STATUS, (k == 0) ? 32'h0 : 32'h2, "csr_rsp_o.data STATUS before start");
      // operands below q, a few pinned to q-1 so that sums wrap
      for (int i = 0; i < N; i++) begin
         rng      = xorshift32(rng);
         a_ops[i] = he_word_t'(rng % 32'(cfg.q));
         rng      = xorshift32(rng);
         b_ops[i] = he_word_t'(rng % 32'(cfg.q));
         if (i % 7 == 3) begin
            a_ops[i] = cfg.q - 1'b1;
         end
         if (i % 5 == 1 || i % 7 == 3) begin
            b_ops[i] = cfg.q - 1'b1;
         end
         mem_inst.words[ADDR_W'(cfg.a_ptr) + ADDR_W'(4 * i)] = a_ops[i];
         mem_inst.words[ADDR_W'(cfg.b_ptr) + ADDR_W'(4 * i)] = b_ops[i];
      end
      for (int i = 0; i < N; i++) begin
         exp_reqs.push_back(make_req(ADDR_W'(cfg.a_ptr) + ADDR_W'(4 * i), 1'b0, '0));
      end
      for (int i = 0; i < N; i++) begin
         exp_reqs.push_back(make_req(ADDR_W'(cfg.b_ptr) + ADDR_W'(4 * i), 1'b0, '0));
      end
      for (int i = 0; i < N; i++) begin
         sum = (64'(a_ops[i]) + 64'(b_ops[i])) % 64'(cfg.q);
         exp_reqs.push_back(make_req(ADDR_W'(cfg.wb_ptr) + ADDR_W'(4 * i), 1'b1,
                                     he_word_t'(sum)));
      end
      exp_reqs.push_back(make_req(INTR_ADDR, 1'b1, '1));

      write_reg(CSR_START, 32'h1);
      // busy set and done cleared by the start
      read_check(CSR_STATUS, 32'h1, "csr_rsp_o.data STATUS after start");
      while (intr_seen <= k) begin
         @(posedge clk);
      end
      while (outstanding) begin
         @(posedge clk);
      end
      wait_idle();
      read_check(CSR_STATUS, 32'h2, "csr_rsp_o.data STATUS after interrupt");
      if (exp_reqs.size() != 0) begin
         $display("t=%0t %0d expected memory requests never appeared", $time, exp_reqs.size());
         errors++;
         exp_reqs.delete();
      end
      report_test($sformatf("row %0d run", k));
   endtask

   initial begin
      reset     = 1'b1;
      csr_cmd_v = 1'b0;
      csr_cmd   = '0;
      runs[0]   = '{q: 27'd134215681, a_ptr: 32'h0000_1000, b_ptr: 32'h0000_2000,
                    wb_ptr: 32'h0000_3000};
      runs[1]   = '{q: 27'd12289, a_ptr: 32'h0001_0000, b_ptr: 32'h0001_4000,
                    wb_ptr: 32'h0001_8000};
      runs[2]   = '{q: 27'd3329, a_ptr: 32'h0002_0000, b_ptr: 32'h0002_0080,
                    wb_ptr: 32'h0002_0100};

      test_base = errors;
      for (int c = 0; c < 4; c++) begin
         @(negedge clk);
         check_quiet("during reset");
      end
      @(posedge clk);
      #1;
      reset = 1'b0;
      for (int c = 0; c < 3; c++) begin
         @(negedge clk);
         check_quiet("after reset");
      end
      read_check(CSR_STATUS, 32'h0, "csr_rsp_o.data STATUS after reset");
      report_test("reset");

      for (int k = 0; k < ROWS; k++) begin
         run_row(k);
      end

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- he_accel_top.f
common/he_cfg_pkg.sv
common/he_bus_pkg.sv
src/he_csr_file.sv
he_core/he_sequencer.sv
he_core/he_dma_engine.sv
he_core/he_poly_buffer.sv
he_core/he_pointwise_adder.sv
src/he_accel_top.sv
tb/he_mem_model.sv
tb/he_accel_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module he_accel_tb -f he_accel_top.f \
   -o he_accel_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/he_accel_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
